/* rvv_dispatch.f */
+incdir+.
dispatch_pkg.sv
dispatch_rob_if.sv
dispatch_rob_match.sv
dispatch_vrf_port_alloc.sv
dispatch_operand_sel.sv
dispatch_issue_ctrl.sv
rvv_dispatch.sv
tb_rvv_dispatch.sv

/* Makefile */
# Verilator build and run of the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_rvv_dispatch
RTL_TOP   ?= rvv_dispatch
FILELIST  ?= rvv_dispatch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --assert --timing
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rvv_dispatch.sv */
// Testbench for rvv_dispatch; random stimulus per scenario, concurrent assertions check each cycle
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module tb_rvv_dispatch;
    import dispatch_pkg::*;

    localparam int NUM_TESTS      = 6;
    localparam int TEST_CYCLES    = 32;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + RESET_CYCLES;
    localparam int META_W         = `DP_ROB_IDX_W + 6 + 3 + `DP_XLEN;
    // Youngest writer outcome
    localparam logic [1:0] WR_NONE = 2'd0;
    localparam logic [1:0] WR_DONE = 2'd1;
    localparam logic [1:0] WR_PEND = 2'd2;

    logic clk = 1'b0;
    logic rst_n;
    logic [1:0]                                  uop_valid;
    uop_t [1:0]                                  uop;
    logic [1:0]                                  uop_ready;
    logic [1:0]                                  alu_valid;
    rs_payload_t [1:0]                           alu_payload;
    logic [1:0]                                  alu_ready;
    logic [1:0]                                  mul_valid;
    rs_payload_t [1:0]                           mul_payload;
    logic [1:0]                                  mul_ready;
    logic [1:0]                                  rob_valid;
    rob_push_t [1:0]                             rob_push;
    logic [1:0]                                  rob_ready;
    logic [`DP_ROB_IDX_W-1:0]                    rob_tail;
    rob_entry_t [`DP_ROB_DEPTH-1:0]              rob_entries;
    logic [3:0][`DP_REG_IDX_W-1:0]               vrf_rd_index;
    logic [3:0][`DP_VLEN-1:0]                    vrf_rd_data;

    // Reference model outputs and the DUT values they are compared with
    logic [1:0]                                  exp_issue;
    logic [1:0]                                  exp_alu_valid;
    logic [1:0]                                  exp_mul_valid;
    logic [3:0][`DP_REG_IDX_W-1:0]               exp_vrf_index;
    logic [1:0][2:0]                             chk_src;
    logic [1:0][2:0][`DP_VLEN-1:0]               exp_operand;
    logic [1:0][2:0][`DP_VLEN-1:0]               got_operand;
    rs_payload_t [1:0]                           got_pl;
    logic [1:0][META_W-1:0]                      exp_meta;
    logic [1:0][META_W-1:0]                      got_meta;
    logic [1:0][6:0]                             exp_push;

    int errors = 0;
    int cycles = 0;

    rvv_dispatch i_rvv_dispatch (.*);

    always #4 clk = ~clk;

    // Word a VRF port returns for a register index
    function automatic logic [`DP_VLEN-1:0] vrf_word(logic [`DP_REG_IDX_W-1:0] r);
        return {(`DP_VLEN / 8){r, 3'b101}};
    endfunction

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            vrf_rd_data[p] = vrf_word(vrf_rd_index[p]);
        end
    end

    // Source slots 0, 1, 2 are vs2, vs1, vs3; vs3 lives in the vd field
    function automatic logic src_on(uop_t u, int s);
        return (s == 0) ? u.vs2_valid : (s == 1) ? u.vs1_valid : u.vs3_valid;
    endfunction

    function automatic logic [`DP_REG_IDX_W-1:0] src_reg(uop_t u, int s);
        return (s == 0) ? u.vs2 : (s == 1) ? u.vs1 : u.vd;
    endfunction

    function automatic logic [1:0] writer_state(uop_t u, int s, logic [2:0] tail,
            rob_entry_t [`DP_ROB_DEPTH-1:0] ents, output logic [`DP_VLEN-1:0] data);
        logic [2:0] idx;
        logic [1:0] st;
        st   = WR_NONE;
        data = '0;
        if (src_on(u, s)) begin
            // tail + 7 is the newest entry, tail itself the oldest
            for (int k = 0; k < `DP_ROB_DEPTH; k++) begin
                idx = tail + 3'(7 - k);
                if (st == WR_NONE && ents[idx].valid && ents[idx].w_index == src_reg(u, s)) begin
                    st   = ents[idx].w_valid ? WR_DONE : WR_PEND;
                    data = ents[idx].w_data;
                end
            end
        end
        return st;
    endfunction

    always_comb begin
        logic [`DP_VLEN-1:0] wdata;
        logic [1:0]          st;
        logic [1:0]          raw;
        logic [1:0]          rs_rdy;
        logic                dep_1on0;
        int                  total;
        int                  port;
        raw           = '0;
        dep_1on0      = 1'b0;
        total         = 0;
        port          = 0;
        chk_src       = '0;
        exp_operand   = '0;
        exp_vrf_index = '0;
        for (int u = 0; u < 2; u++) begin
            for (int s = 0; s < 3; s++) begin
                total += int'(src_on(uop[u], s));
            end
        end
        for (int u = 0; u < 2; u++) begin
            for (int s = 0; s < 3; s++) begin
                st = writer_state(uop[u], s, rob_tail, rob_entries, wdata);
                if (st == WR_PEND && uop_valid[u]) raw[u] = 1'b1;
                if (src_on(uop[u], s) && (u == 0 || total <= 4)) begin
                    chk_src[u][s]     = 1'b1;
                    exp_operand[u][s] = (st == WR_DONE) ? wdata : vrf_word(src_reg(uop[u], s));
                    exp_vrf_index[port[1:0]] = src_reg(uop[u], s);
                    port++;
                end
                if (u == 1 && src_on(uop[1], s) && src_reg(uop[1], s) == uop[0].vd &&
                    uop_valid[0] && uop[0].vd_valid) begin
                    dep_1on0 = 1'b1;
                end
            end
        end
        for (int i = 0; i < 2; i++) begin
            rs_rdy[i]   = (uop[i].exe_unit == EXE_MUL) ? mul_ready[i] : alu_ready[i];
            got_pl[i]   = (uop[i].exe_unit == EXE_MUL) ? mul_payload[i] : alu_payload[i];
            exp_meta[i] = {rob_tail + 3'(i), uop[i].funct6, uop[i].vs1_valid,
                           uop[i].vs2_valid, uop[i].vs3_valid, uop[i].rs1_data};
            got_meta[i] = {got_pl[i].rob_tag, got_pl[i].funct6, got_pl[i].vs1_valid,
                           got_pl[i].vs2_valid, got_pl[i].vs3_valid, got_pl[i].rs1_data};
            exp_push[i] = {uop[i].vd, uop[i].vd_valid, uop[i].last_uop};
            got_operand[i][0] = got_pl[i].vs2_data;
            got_operand[i][1] = got_pl[i].vs1_data;
            got_operand[i][2] = got_pl[i].vs3_data;
        end
        exp_issue[0] = uop_valid[0] && !raw[0] && rs_rdy[0] && rob_ready[0];
        exp_issue[1] = exp_issue[0] && uop_valid[1] && !raw[1] && !dep_1on0 && total <= 4 &&
                       rs_rdy[1] && rob_ready[1];
        for (int i = 0; i < 2; i++) begin
            exp_alu_valid[i] = exp_issue[i] && uop[i].exe_unit == EXE_ALU;
            exp_mul_valid[i] = exp_issue[i] && uop[i].exe_unit == EXE_MUL;
        end
    end

    task automatic mismatch(string sig, logic [`DP_VLEN-1:0] exp, logic [`DP_VLEN-1:0] got);
        $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, sig, exp, got);
        errors++;
    endtask

    a_uop_ready: assert property (@(posedge clk) disable iff (!rst_n) uop_ready == exp_issue)
        else mismatch("uop_ready", exp_issue, uop_ready);
    a_rob_valid: assert property (@(posedge clk) disable iff (!rst_n) rob_valid == exp_issue)
        else mismatch("rob_valid", exp_issue, rob_valid);
    a_alu_valid: assert property (@(posedge clk) disable iff (!rst_n) alu_valid == exp_alu_valid)
        else mismatch("alu_valid", exp_alu_valid, alu_valid);
    a_mul_valid: assert property (@(posedge clk) disable iff (!rst_n) mul_valid == exp_mul_valid)
        else mismatch("mul_valid", exp_mul_valid, mul_valid);
    a_vrf_index: assert property (@(posedge clk) disable iff (!rst_n)
        vrf_rd_index == exp_vrf_index)
        else mismatch("vrf_rd_index", exp_vrf_index, vrf_rd_index);

    genvar gu, gs;
    generate
        for (gu = 0; gu < 2; gu++) begin : gen_slot
            a_meta: assert property (@(posedge clk) disable iff (!rst_n)
                got_meta[gu] == exp_meta[gu])
                else mismatch($sformatf("payload[%0d] tag/funct6/rs1", gu),
                              exp_meta[gu], got_meta[gu]);
            a_push: assert property (@(posedge clk) disable iff (!rst_n)
                rob_push[gu] == exp_push[gu])
                else mismatch($sformatf("rob_push[%0d]", gu), exp_push[gu], rob_push[gu]);
            for (gs = 0; gs < 3; gs++) begin : gen_src
                a_operand: assert property (@(posedge clk) disable iff (!rst_n)
                    chk_src[gu][gs] |-> got_operand[gu][gs] == exp_operand[gu][gs])
                    else mismatch($sformatf("operand[%0d][%0d]", gu, gs),
                                  exp_operand[gu][gs], got_operand[gu][gs]);
            end
        end
    endgenerate

    // Random micro-op with n sources; hi picks the register half
    function automatic uop_t rand_uop(logic hi, int n);
        uop_t       u;
        logic [2:0] m;
        u = uop_t'($bits(uop_t)'({$urandom, $urandom}));
        m = 3'($urandom);
        while ($countones(m) != n) m = 3'($urandom);
        u.vs2       = {hi, 4'($urandom)};
        u.vs1       = {hi, 4'($urandom)};
        u.vd        = {hi, 4'($urandom)};
        u.vs2_valid = m[0];
        u.vs1_valid = m[1];
        u.vs3_valid = m[2];
        return u;
    endfunction

    function automatic int first_src(uop_t u);
        return u.vs2_valid ? 0 : u.vs1_valid ? 1 : 2;
    endfunction

    task automatic drive_idle();
        uop_valid = 2'b00;
        uop       = '0;
        alu_ready = 2'b11;
        mul_ready = 2'b11;
        rob_ready = 2'b11;
        rob_tail  = '0;
        for (int k = 0; k < `DP_ROB_DEPTH; k++) begin
            rob_entries[k] = '0;
        end
    endtask

    task automatic drive_case(int t, int c);
        int         n0;
        int         n1;
        int         u;
        int         s;
        logic [2:0] pos;
        u         = c % 2;
        uop_valid = 2'b11;
        alu_ready = 2'b11;
        mul_ready = 2'b11;
        rob_ready = 2'b11;
        rob_tail  = 3'($urandom);
        for (int k = 0; k < `DP_ROB_DEPTH; k++) begin
            rob_entries[k]       = rob_entry_t'($bits(rob_entry_t)'({5{$urandom}}));
            rob_entries[k].valid = 1'b0;
        end
        n0 = $urandom_range(2, 0);
        n1 = $urandom_range(2, 0);
        if (t == 1) n0 = $urandom_range(3, 0);
        if (t == 1) n1 = $urandom_range((n0 > 1) ? 4 - n0 : 3, 0);
        if (t == 2 || t == 3) n0 = $urandom_range(2, 1);
        if (t == 2 || t == 3 || t == 4) n1 = $urandom_range(2, 1);
        if (t == 5) n0 = 3;
        if (t == 5) n1 = 2 + c % 2;
        uop[0] = rand_uop(1'b0, n0);
        uop[1] = rand_uop(1'b1, n1);
        pos    = rob_tail - 3'd1 - 3'($urandom_range(3, 0));
        case (t)
            2, 3: begin
                // Youngest writer of one source, pending in test 2 and done in test 3
                rob_entries[pos].valid   = 1'b1;
                rob_entries[pos].w_valid = (t == 3);
                rob_entries[pos].w_index = src_reg(uop[u], first_src(uop[u]));
                if (t == 3) begin
                    pos = pos - 3'd1 - 3'($urandom_range(2, 0));
                    rob_entries[pos].valid   = 1'b1;
                    rob_entries[pos].w_valid = 1'($urandom);
                    rob_entries[pos].w_index = src_reg(uop[u], first_src(uop[u]));
                end
            end
            4: begin
                s = first_src(uop[1]);
                uop[0].vd_valid = 1'b1;
                if (s == 0) uop[1].vs2 = uop[0].vd;
                if (s == 1) uop[1].vs1 = uop[0].vd;
                if (s == 2) uop[1].vd = uop[0].vd;
            end
            6: begin
                alu_ready = 2'($urandom);
                mul_ready = 2'($urandom);
                if (uop[0].exe_unit == EXE_ALU) alu_ready[0] = 1'b1;
                else mul_ready[0] = 1'b1;
                if (uop[1].exe_unit == EXE_ALU) alu_ready[1] = 1'b1;
                else mul_ready[1] = 1'b1;
                if ($urandom_range(1, 0) == 0) rob_ready[u] = 1'b0;
                else if (uop[u].exe_unit == EXE_ALU) alu_ready[u] = 1'b0;
                else mul_ready[u] = 1'b0;
            end
            default: ;
        endcase
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        string names[NUM_TESTS];
        int    err_start;
        int    failed;
        names  = '{"clean dual issue", "ROB RAW stall", "ROB bypass youngest",
                   "micro-op 1 on micro-op 0", "VRF port overflow", "back-pressure"};
        failed = 0;
        void'($urandom(32'hea6b_2c2e));
        rst_n  = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            err_start = errors;
            for (int c = 0; c < TEST_CYCLES; c++) begin
                @(negedge clk);
                drive_case(t, c);
            end
            @(negedge clk);
            drive_idle();
            if (errors != err_start) failed++;
            $display("Test %0d %s: %s, %0d errors", t, names[t-1],
                     (errors == err_start) ? "ok" : "FAILED", errors - err_start);
        end
        @(negedge clk);
        $display("Tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rvv_dispatch.sv */
// Top level of the vector dispatch stage, between the micro-op queue, the VRF, the ROB and RS
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module rvv_dispatch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // Micro-op queue
    input  logic [`DP_NUM_UOP-1:0]                        uop_valid,
    input  dispatch_pkg::uop_t [`DP_NUM_UOP-1:0]          uop,
    output logic [`DP_NUM_UOP-1:0]                        uop_ready,
    // ALU reservation station
    output logic [`DP_NUM_UOP-1:0]                        alu_valid,
    output dispatch_pkg::rs_payload_t [`DP_NUM_UOP-1:0]   alu_payload,
    input  logic [`DP_NUM_UOP-1:0]                        alu_ready,
    // MUL reservation station
    output logic [`DP_NUM_UOP-1:0]                        mul_valid,
    output dispatch_pkg::rs_payload_t [`DP_NUM_UOP-1:0]   mul_payload,
    input  logic [`DP_NUM_UOP-1:0]                        mul_ready,
    // ROB push and entry view
    output logic [`DP_NUM_UOP-1:0]                        rob_valid,
    output dispatch_pkg::rob_push_t [`DP_NUM_UOP-1:0]     rob_push,
    input  logic [`DP_NUM_UOP-1:0]                        rob_ready,
    input  logic [`DP_ROB_IDX_W-1:0]                      rob_tail,
    input  dispatch_pkg::rob_entry_t [`DP_ROB_DEPTH-1:0]  rob_entries,
    // VRF read, data returns in the same cycle
    output logic [`DP_NUM_VRF_PORT-1:0][`DP_REG_IDX_W-1:0] vrf_rd_index,
    input  logic [`DP_NUM_VRF_PORT-1:0][`DP_VLEN-1:0]      vrf_rd_data
);
    import dispatch_pkg::*;

    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0][PORT_SEL_W-1:0] port_sel;
    logic                                                    strct_hazard;
    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0][`DP_VLEN-1:0]   operand;
    exe_unit_e [`DP_NUM_UOP-1:0]                             uop_unit;
    rs_payload_t [`DP_NUM_UOP-1:0]                           rs_payload;

    dispatch_rob_if rob_if ();

    dispatch_rob_match u_rob_match (
        .uop_valid   (uop_valid),
        .uop         (uop),
        .rob_tail    (rob_tail),
        .rob_entries (rob_entries),
        .rob         (rob_if.match)
    );

    dispatch_vrf_port_alloc u_vrf_port_alloc (
        .uop          (uop),
        .vrf_rd_index (vrf_rd_index),
        .port_sel     (port_sel),
        .strct_hazard (strct_hazard)
    );

    dispatch_operand_sel u_operand_sel (
        .rob         (rob_if.sel),
        .port_sel    (port_sel),
        .vrf_rd_data (vrf_rd_data),
        .operand     (operand)
    );

    dispatch_issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_valid    (uop_valid),
        .uop_unit     (uop_unit),
        .strct_hazard (strct_hazard),
        .alu_ready    (alu_ready),
        .mul_ready    (mul_ready),
        .rob_ready    (rob_ready),
        .rob          (rob_if.ctrl),
        .uop_ready    (uop_ready),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .rob_valid    (rob_valid)
    );

    // Payload fields, driven whether or not the slot issues
    always_comb begin
        for (int i = 0; i < `DP_NUM_UOP; i++) begin
            uop_unit[i]             = uop[i].exe_unit;
            rs_payload[i].rob_tag   = rob_tail + `DP_ROB_IDX_W'(i);
            rs_payload[i].funct6    = uop[i].funct6;
            rs_payload[i].vs1_data  = operand[i][SRC_VS1];
            rs_payload[i].vs1_valid = uop[i].vs1_valid;
            rs_payload[i].vs2_data  = operand[i][SRC_VS2];
            rs_payload[i].vs2_valid = uop[i].vs2_valid;
            rs_payload[i].vs3_data  = operand[i][SRC_VS3];
            rs_payload[i].vs3_valid = uop[i].vs3_valid;
            rs_payload[i].rs1_data  = uop[i].rs1_data;
            rob_push[i].vd_index    = uop[i].vd;
            rob_push[i].vd_valid    = uop[i].vd_valid;
            rob_push[i].last_uop    = uop[i].last_uop;
        end
    end

    // Both stations see the same payload; valid decides who takes it
    assign alu_payload = rs_payload;
    assign mul_payload = rs_payload;

endmodule

/* dispatch_issue_ctrl.sv */
// In-order dual-issue control of the dispatch stage, driving every valid and ready
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_issue_ctrl (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [`DP_NUM_UOP-1:0]                     uop_valid,
    input  dispatch_pkg::exe_unit_e [`DP_NUM_UOP-1:0]  uop_unit,
    input  logic                                       strct_hazard,
    input  logic [`DP_NUM_UOP-1:0]                     alu_ready,
    input  logic [`DP_NUM_UOP-1:0]                     mul_ready,
    input  logic [`DP_NUM_UOP-1:0]                     rob_ready,
    dispatch_rob_if.ctrl                               rob,
    output logic [`DP_NUM_UOP-1:0]                     uop_ready,
    output logic [`DP_NUM_UOP-1:0]                     alu_valid,
    output logic [`DP_NUM_UOP-1:0]                     mul_valid,
    output logic [`DP_NUM_UOP-1:0]                     rob_valid
);
    import dispatch_pkg::*;

    logic [`DP_NUM_UOP-1:0] rs_ready;
    logic [`DP_NUM_UOP-1:0] issue;

    // Ready of the station each slot targets
    always_comb begin
        for (int i = 0; i < `DP_NUM_UOP; i++) begin
            rs_ready[i] = (uop_unit[i] == EXE_ALU) ? alu_ready[i] : mul_ready[i];
        end
    end

    assign issue[0] = uop_valid[0] & ~rob.rob_raw[0] & rs_ready[0] & rob_ready[0];

    // Micro-op 1 goes only together with micro-op 0
    assign issue[1] = issue[0] & uop_valid[1] & ~rob.rob_raw[1] & ~rob.uop_raw &
                      ~strct_hazard & rs_ready[1] & rob_ready[1];

    always_comb begin
        for (int i = 0; i < `DP_NUM_UOP; i++) begin
            alu_valid[i] = issue[i] & (uop_unit[i] == EXE_ALU);
            mul_valid[i] = issue[i] & (uop_unit[i] == EXE_MUL);
        end
    end

    // Queue pops and ROB pushes follow issue exactly
    assign uop_ready = issue;
    assign rob_valid = issue;

    // Whatever station slot 1 reaches, slot 0 reached one too
    a_in_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        (alu_valid[1] | mul_valid[1]) |-> (alu_valid[0] | mul_valid[0]) && rob_valid[0]
    ) else $error("issue_ctrl: micro-op 1 issued without micro-op 0");

    genvar g;
    generate
        for (g = 0; g < `DP_NUM_UOP; g++) begin : gen_one_station
            a_one_station: assert property (
                @(posedge clk) disable iff (!rst_n)
                !(alu_valid[g] && mul_valid[g])
            ) else $error("issue_ctrl: slot %0d sent to both stations", g);
        end
    endgenerate

endmodule

/* dispatch_operand_sel.sv */
// Picks each source operand from ROB bypass data or from its allocated VRF read port
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_operand_sel (
    dispatch_rob_if.sel                                        rob,
    input  logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0]
                 [dispatch_pkg::PORT_SEL_W-1:0]                port_sel,
    input  logic [`DP_NUM_VRF_PORT-1:0][`DP_VLEN-1:0]          vrf_rd_data,
    output logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0][`DP_VLEN-1:0] operand
);

    // Bypass wins; otherwise the port allocated to this source
    always_comb begin
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            for (int s = 0; s < `DP_NUM_SRC; s++) begin
                if (rob.byp_hit[u][s]) begin
                    operand[u][s] = rob.byp_data[u][s];
                end else begin
                    operand[u][s] = vrf_rd_data[port_sel[u][s]];
                end
            end
        end
    end

endmodule

/* dispatch_vrf_port_alloc.sv */
// Hands out the shared VRF read ports to used sources in order and flags the structural hazard
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_vrf_port_alloc (
    input  dispatch_pkg::uop_t [`DP_NUM_UOP-1:0]                     uop,
    output logic [`DP_NUM_VRF_PORT-1:0][`DP_REG_IDX_W-1:0]           vrf_rd_index,
    output logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0]
                 [dispatch_pkg::PORT_SEL_W-1:0]                      port_sel,
    output logic                                                     strct_hazard
);
    import dispatch_pkg::*;

    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0] src_used;
    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0] src_grant;

    always_comb begin
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            for (int s = 0; s < `DP_NUM_SRC; s++) begin
                src_used[u][s] = uop_src_valid(uop[u], src_e'(s));
            end
        end
    end

    // Micro-op 0 alone never exceeds the ports, so only micro-op 1 can overflow
    assign strct_hazard = ($countones(src_used) > `DP_NUM_VRF_PORT);

    // Ports in order: uop0 vs2, vs1, vs3, then uop1 vs2, vs1, vs3
    always_comb begin
        logic [PORT_SEL_W:0] next_port;
        next_port    = '0;
        vrf_rd_index = '0;
        port_sel     = '0;
        src_grant    = '0;
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            for (int s = 0; s < `DP_NUM_SRC; s++) begin
                if (src_used[u][s] && (u == 0 || !strct_hazard)) begin
                    src_grant[u][s] = 1'b1;
                    port_sel[u][s]  = next_port[PORT_SEL_W-1:0];
                    vrf_rd_index[next_port[PORT_SEL_W-1:0]] =
                        uop_src_index(uop[u], src_e'(s));
                    next_port = next_port + 1'b1;
                end
            end
        end
    end

    // Each granted source owns its port exclusively
    always_comb begin
        logic [`DP_NUM_VRF_PORT-1:0] claimed;
        logic                        port_clash;
        claimed    = '0;
        port_clash = 1'b0;
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            for (int s = 0; s < `DP_NUM_SRC; s++) begin
                if (src_grant[u][s]) begin
                    port_clash           = port_clash | claimed[port_sel[u][s]];
                    claimed[port_sel[u][s]] = 1'b1;
                end
            end
        end
        assert final (!port_clash)
            else $error("vrf_port_alloc: two sources share one read port");
    end

endmodule

/* dispatch_rob_match.sv */
// Finds the youngest ROB writer of every source and flags RAW hazards for the dispatch stage
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_rob_match (
    input  logic [`DP_NUM_UOP-1:0]                        uop_valid,
    input  dispatch_pkg::uop_t [`DP_NUM_UOP-1:0]          uop,
    input  logic [`DP_ROB_IDX_W-1:0]                      rob_tail,
    input  dispatch_pkg::rob_entry_t [`DP_ROB_DEPTH-1:0]  rob_entries,
    dispatch_rob_if.match                                 rob
);
    import dispatch_pkg::*;

    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0]               byp_hit;
    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0][`DP_VLEN-1:0] byp_data;
    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0]               src_raw;
    logic                                                  vd0_live;

    // Walk back from the newest entry; the first match decides bypass or stall
    always_comb begin
        logic                     found;
        logic [`DP_ROB_IDX_W-1:0] idx;
        logic [`DP_REG_IDX_W-1:0] src_idx;
        found    = 1'b0;
        idx      = '0;
        src_idx  = '0;
        byp_hit  = '0;
        byp_data = '0;
        src_raw  = '0;
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            for (int s = 0; s < `DP_NUM_SRC; s++) begin
                found   = 1'b0;
                src_idx = uop_src_index(uop[u], src_e'(s));
                for (int k = 1; k <= `DP_ROB_DEPTH; k++) begin
                    // k wraps to the tail entry itself on the last step
                    idx = rob_tail - `DP_ROB_IDX_W'(k);
                    if (!found && uop_src_valid(uop[u], src_e'(s)) &&
                        rob_entries[idx].valid && rob_entries[idx].w_index == src_idx) begin
                        found = 1'b1;
                        if (rob_entries[idx].w_valid) begin
                            byp_hit[u][s]  = 1'b1;
                            byp_data[u][s] = rob_entries[idx].w_data;
                        end else begin
                            src_raw[u][s] = 1'b1;
                        end
                    end
                end
            end
        end
    end

    assign rob.byp_hit  = byp_hit;
    assign rob.byp_data = byp_data;

    always_comb begin
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            rob.rob_raw[u] = uop_valid[u] & (|src_raw[u]);
        end
    end

    // Micro-op 0 result is not in the ROB yet, so micro-op 1 must wait for it
    assign vd0_live = uop_valid[0] & uop[0].vd_valid;

    always_comb begin
        rob.uop_raw = 1'b0;
        for (int s = 0; s < `DP_NUM_SRC; s++) begin
            if (vd0_live && uop_src_valid(uop[1], src_e'(s)) &&
                uop_src_index(uop[1], src_e'(s)) == uop[0].vd) begin
                rob.uop_raw = 1'b1;
            end
        end
    end

    // Sources naming one register share one youngest writer
    // None of them is bypassed while another stalls on it
    always_comb begin
        logic split;
        split = 1'b0;
        for (int u = 0; u < `DP_NUM_UOP; u++) begin
            for (int s = 0; s < `DP_NUM_SRC; s++) begin
                for (int v = 0; v < `DP_NUM_UOP; v++) begin
                    for (int t = 0; t < `DP_NUM_SRC; t++) begin
                        if (byp_hit[u][s] && src_raw[v][t] &&
                            uop_src_index(uop[u], src_e'(s)) ==
                            uop_src_index(uop[v], src_e'(t))) begin
                            split = 1'b1;
                        end
                    end
                end
            end
        end
        assert final (!split)
            else $error("rob_match: one register both bypassed and stalled");
    end

endmodule

/* dispatch_rob_if.sv */
// ROB match results, passed from ROB matching to operand selection and issue control
`timescale 1ns/1ps
`include "dispatch_settings.svh"

interface dispatch_rob_if;

    // Youngest writer has produced its data
    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0]               byp_hit;
    logic [`DP_NUM_UOP-1:0][`DP_NUM_SRC-1:0][`DP_VLEN-1:0] byp_data;
    // Youngest writer still pending
    logic [`DP_NUM_UOP-1:0]                                rob_raw;
    // Micro-op 1 reads what micro-op 0 writes
    logic                                                  uop_raw;

    modport match (
        output byp_hit,
        output byp_data,
        output rob_raw,
        output uop_raw
    );

    modport sel (input byp_hit, input byp_data);

    modport ctrl (input rob_raw, input uop_raw);

endinterface

/* dispatch_pkg.sv */
// Types shared by the dispatch RTL and testbench; compile before any module that imports it
`include "dispatch_settings.svh"

package dispatch_pkg;

    // Target reservation station
    typedef enum logic [0:0] {
        EXE_ALU = 1'b0,
        EXE_MUL = 1'b1
    } exe_unit_e;

    // Source slot, listed in VRF port allocation order
    typedef enum logic [1:0] {
        SRC_VS2 = 2'd0,
        SRC_VS1 = 2'd1,
        SRC_VS3 = 2'd2
    } src_e;

    localparam int PORT_SEL_W = $clog2(`DP_NUM_VRF_PORT);

    typedef struct packed {
        exe_unit_e                exe_unit;
        logic [5:0]               funct6;
        logic [`DP_REG_IDX_W-1:0] vs1;
        logic [`DP_REG_IDX_W-1:0] vs2;
        logic [`DP_REG_IDX_W-1:0] vd;
        logic                     vs1_valid;
        logic                     vs2_valid;
        logic                     vs3_valid;
        logic                     vd_valid;
        logic [`DP_XLEN-1:0]      rs1_data;
        logic                     last_uop;
    } uop_t;

    typedef struct packed {
        logic                     valid;
        logic                     w_valid;
        logic [`DP_REG_IDX_W-1:0] w_index;
        logic [`DP_VLEN-1:0]      w_data;
    } rob_entry_t;

    typedef struct packed {
        logic [`DP_ROB_IDX_W-1:0] rob_tag;
        logic [5:0]               funct6;
        logic [`DP_VLEN-1:0]      vs1_data;
        logic                     vs1_valid;
        logic [`DP_VLEN-1:0]      vs2_data;
        logic                     vs2_valid;
        logic [`DP_VLEN-1:0]      vs3_data;
        logic                     vs3_valid;
        logic [`DP_XLEN-1:0]      rs1_data;
    } rs_payload_t;

    typedef struct packed {
        logic [`DP_REG_IDX_W-1:0] vd_index;
        logic                     vd_valid;
        logic                     last_uop;
    } rob_push_t;

    // Whether a micro-op reads the given source slot
    function automatic logic uop_src_valid(uop_t u, src_e s);
        case (s)
            SRC_VS2: return u.vs2_valid;
            SRC_VS1: return u.vs1_valid;
            default: return u.vs3_valid;
        endcase
    endfunction

    // Register index of a source slot; vs3 is read from the vd index
    function automatic logic [`DP_REG_IDX_W-1:0] uop_src_index(uop_t u, src_e s);
        case (s)
            SRC_VS2: return u.vs2;
            SRC_VS1: return u.vs1;
            default: return u.vd;
        endcase
    endfunction

endpackage

/* dispatch_settings.svh */
// Sizing macros for the vector dispatch stage, included by the package, the RTL and the testbench
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Micro-ops taken from the queue per cycle
`define DP_NUM_UOP      2
// Shared VRF read ports
`define DP_NUM_VRF_PORT 4

`define DP_ROB_DEPTH    8
`define DP_ROB_IDX_W    3

`define DP_VLEN         128
`define DP_REG_IDX_W    5
`define DP_XLEN         32

// Source slots per micro-op: vs2, vs1, vs3
`define DP_NUM_SRC      3

`endif
